// ==== hdl/jacobian_consts.svh ====
// Jacobian engine constants.
// Widths, matrix size, command FIFO depth and result credit count.
`ifndef JACOBIAN_CONSTS_SVH
`define JACOBIAN_CONSTS_SVH

// Signed operand element.
`define JAC_DATA_W 9

// Result element, three 18-bit products summed.
`define JAC_ACC_W 20

// Matrix dimension.
`define JAC_N 3

// Command tag width.
`define JAC_TAG_W 4

// Sequencer FIFO depth, also the upstream command credits after reset.
`define JAC_CMD_DEPTH 2

// Result credits held after reset.
`define JAC_RES_CREDITS 2

`endif

// ==== hdl/jacobian_pkg.sv ====
// Jacobian engine types.
// Opcode, operand and result matrices, command, unit job and result words.
`include "jacobian_consts.svh"

package jacobian_pkg;

	// Selects the unit that runs a command.
	typedef enum logic {
		OP_MAT   = 1'b0,
		OP_ARRAY = 1'b1
	} op_e;

	// One signed operand element.
	typedef logic signed [`JAC_DATA_W-1:0] elem_t;

	// One signed result element.
	typedef logic signed [`JAC_ACC_W-1:0] acc_t;

	// Nine elements, row-major, index is row*N + col.
	typedef elem_t [`JAC_N*`JAC_N-1:0] mat_t;

	typedef acc_t [`JAC_N*`JAC_N-1:0] res_mat_t;

	// Command as sent by upstream.
	typedef struct packed {
		logic [`JAC_TAG_W-1:0] tag;
		op_e                   op;
		mat_t                  a;
		mat_t                  b;
	} cmd_t;

	// Work item for one multiplier unit.
	// The port it arrives on implies the unit.
	typedef struct packed {
		logic [`JAC_TAG_W-1:0] tag;
		mat_t                  a;
		mat_t                  b;
	} job_t;

	// Finished result, tagged with its command.
	typedef struct packed {
		logic [`JAC_TAG_W-1:0] tag;
		op_e                   op;
		res_mat_t              c;
	} res_t;

endpackage

// ==== hdl/jacobian_seq.sv ====
// Command sequencer.
// Buffers commands, returns credits upstream and dispatches jobs by opcode.
`timescale 1ns/1ps
`include "jacobian_consts.svh"

module jacobian_seq (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                cmd_valid,
	input  jacobian_pkg::cmd_t  cmd,
	output logic                cmd_credit,
	output logic                mat_valid,
	input  logic                mat_ready,
	output jacobian_pkg::job_t  mat_job,
	output logic                arr_valid,
	input  logic                arr_ready,
	output jacobian_pkg::job_t  arr_job
);
	import jacobian_pkg::*;

	localparam int PTR_W = $clog2(`JAC_CMD_DEPTH);
	localparam int CNT_W = $clog2(`JAC_CMD_DEPTH + 1);

	cmd_t             fifo [`JAC_CMD_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             push;
	logic             pop;
	cmd_t             head;
	job_t             head_job;

	// Upstream only sends while it holds a credit, so a push never overflows.
	assign push = cmd_valid;
	assign head = fifo[rd_ptr];

	assign head_job = '{tag: head.tag, a: head.a, b: head.b};
	assign mat_job  = head_job;
	assign arr_job  = head_job;

	// The head waits for its own unit; later entries queue behind it.
	assign mat_valid = (count != '0) && (head.op == OP_MAT);
	assign arr_valid = (count != '0) && (head.op == OP_ARRAY);

	assign pop        = (mat_valid && mat_ready) || (arr_valid && arr_ready);
	assign cmd_credit = pop;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				if (wr_ptr == PTR_W'(`JAC_CMD_DEPTH - 1))
					wr_ptr <= '0;
				else
					wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				if (rd_ptr == PTR_W'(`JAC_CMD_DEPTH - 1))
					rd_ptr <= '0;
				else
					rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			fifo[wr_ptr] <= cmd;
	end

endmodule

// ==== hdl/mat_mult.sv ====
// Sequential 3x3 matrix multiplier.
// Computes one dot product per cycle and holds the full result until taken.
`timescale 1ns/1ps
`include "jacobian_consts.svh"

module mat_mult (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                job_valid,
	output logic                job_ready,
	input  jacobian_pkg::job_t  job,
	output logic                res_valid,
	input  logic                res_ready,
	output jacobian_pkg::res_t  res
);
	import jacobian_pkg::*;

	localparam int IDX_W = $clog2(`JAC_N);

	logic                         busy;
	logic [IDX_W-1:0]             row;
	logic [IDX_W-1:0]             col;
	logic [`JAC_TAG_W-1:0]        tag_q;
	mat_t                         a_q;
	mat_t                         b_q;
	res_mat_t                     c_q;
	logic signed [2*`JAC_DATA_W-1:0] prod [`JAC_N];
	acc_t                         dot;

	// Idle means neither computing nor holding an unaccepted result.
	assign job_ready = !busy && !res_valid;

	// Row of a times column of b.
	always_comb begin
		dot = '0;
		for (int k = 0; k < `JAC_N; k++) begin
			prod[k] = a_q[row*`JAC_N + k] * b_q[k*`JAC_N + col];
			dot     = dot + prod[k];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy      <= 1'b0;
			row       <= '0;
			col       <= '0;
			res_valid <= 1'b0;
		end else begin
			if (job_valid && job_ready) begin
				busy <= 1'b1;
				row  <= '0;
				col  <= '0;
			end else if (busy) begin
				if (col == IDX_W'(`JAC_N - 1)) begin
					col <= '0;
					row <= row + 1'b1;
					if (row == IDX_W'(`JAC_N - 1)) begin
						busy      <= 1'b0;
						res_valid <= 1'b1;
					end
				end else begin
					col <= col + 1'b1;
				end
			end else if (res_valid && res_ready) begin
				res_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (job_valid && job_ready) begin
			tag_q <= job.tag;
			a_q   <= job.a;
			b_q   <= job.b;
		end
		if (busy)
			c_q[row*`JAC_N + col] <= dot;
	end

	assign res = '{tag: tag_q, op: OP_MAT, c: c_q};

endmodule

// ==== hdl/array_mult.sv ====
// Pipelined element-wise 3x3 multiplier.
// Products in the first stage, sign extension in the second.
`timescale 1ns/1ps
`include "jacobian_consts.svh"

module array_mult (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                job_valid,
	output logic                job_ready,
	input  jacobian_pkg::job_t  job,
	output logic                res_valid,
	input  logic                res_ready,
	output jacobian_pkg::res_t  res
);
	import jacobian_pkg::*;

	localparam int PROD_W = 2*`JAC_DATA_W;

	logic                      advance;
	logic                      s1_valid;
	logic [`JAC_TAG_W-1:0]     s1_tag;
	logic signed [PROD_W-1:0]  s1_prod [`JAC_N*`JAC_N];
	logic                      s2_valid;
	logic [`JAC_TAG_W-1:0]     s2_tag;
	res_mat_t                  s2_c;

	// A full, unaccepted output stage freezes both stages.
	assign advance   = !s2_valid || res_ready;
	assign job_ready = advance;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
		end else if (advance) begin
			s1_valid <= job_valid;
			s2_valid <= s1_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			s1_tag <= job.tag;
			s2_tag <= s1_tag;
			for (int k = 0; k < `JAC_N*`JAC_N; k++) begin
				s1_prod[k] <= job.a[k] * job.b[k];
				s2_c[k]    <= {{(`JAC_ACC_W - PROD_W){s1_prod[k][PROD_W-1]}}, s1_prod[k]};
			end
		end
	end

	assign res_valid = s2_valid;
	assign res       = '{tag: s2_tag, op: OP_ARRAY, c: s2_c};

endmodule

// ==== hdl/result_arbiter.sv ====
// Round-robin result arbiter.
// Merges both units onto one registered output under downstream credits.
`timescale 1ns/1ps
`include "jacobian_consts.svh"

module result_arbiter (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                mat_res_valid,
	output logic                mat_res_ready,
	input  jacobian_pkg::res_t  mat_res,
	input  logic                arr_res_valid,
	output logic                arr_res_ready,
	input  jacobian_pkg::res_t  arr_res,
	output logic                res_valid,
	output jacobian_pkg::res_t  res,
	input  logic                res_credit
);

	localparam int CRED_W = $clog2(`JAC_RES_CREDITS + 1);

	logic [CRED_W-1:0] credits;
	logic              has_credit;
	logic              last_arr;
	logic              grant;

	assign has_credit = (credits != '0);

	// On a tie the unit that lost last time wins.
	assign mat_res_ready = has_credit && mat_res_valid && (!arr_res_valid || last_arr);
	assign arr_res_ready = has_credit && arr_res_valid && (!mat_res_valid || !last_arr);
	assign grant         = mat_res_ready || arr_res_ready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			credits   <= CRED_W'(`JAC_RES_CREDITS);
			last_arr  <= 1'b0;
			res_valid <= 1'b0;
		end else begin
			res_valid <= grant;
			if (grant)
				last_arr <= arr_res_ready;
			// A credit is spent when the result is taken from its unit.
			case ({grant, res_credit})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (mat_res_ready)
			res <= mat_res;
		else if (arr_res_ready)
			res <= arr_res;
	end

endmodule

// ==== hdl/jacobian_top.sv ====
// Jacobian product engine top level.
// Sequencer feeds the two multiplier units, the arbiter merges their results.
`timescale 1ns/1ps

module jacobian_top (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                cmd_valid,
	input  jacobian_pkg::cmd_t  cmd,
	output logic                cmd_credit,
	output logic                res_valid,
	output jacobian_pkg::res_t  res,
	input  logic                res_credit
);
	import jacobian_pkg::*;

	logic mat_valid;
	logic mat_ready;
	job_t mat_job;
	logic arr_valid;
	logic arr_ready;
	job_t arr_job;

	logic mat_res_valid;
	logic mat_res_ready;
	res_t mat_res;
	logic arr_res_valid;
	logic arr_res_ready;
	res_t arr_res;

	jacobian_seq jacobian_seq_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.cmd_valid  (cmd_valid),
		.cmd        (cmd),
		.cmd_credit (cmd_credit),
		.mat_valid  (mat_valid),
		.mat_ready  (mat_ready),
		.mat_job    (mat_job),
		.arr_valid  (arr_valid),
		.arr_ready  (arr_ready),
		.arr_job    (arr_job)
	);

	mat_mult mat_mult_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.job_valid (mat_valid),
		.job_ready (mat_ready),
		.job       (mat_job),
		.res_valid (mat_res_valid),
		.res_ready (mat_res_ready),
		.res       (mat_res)
	);

	array_mult array_mult_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.job_valid (arr_valid),
		.job_ready (arr_ready),
		.job       (arr_job),
		.res_valid (arr_res_valid),
		.res_ready (arr_res_ready),
		.res       (arr_res)
	);

	result_arbiter result_arbiter_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.mat_res_valid (mat_res_valid),
		.mat_res_ready (mat_res_ready),
		.mat_res       (mat_res),
		.arr_res_valid (arr_res_valid),
		.arr_res_ready (arr_res_ready),
		.arr_res       (arr_res),
		.res_valid     (res_valid),
		.res           (res),
		.res_credit    (res_credit)
	);

endmodule

// ==== testbench/jacobian_tb.sv ====
// Jacobian engine testbench.
// Random commands of both kinds, checked by tag against a reference model.
`timescale 1ns/1ps
`include "jacobian_consts.svh"

module jacobian_tb;
	import jacobian_pkg::*;

	localparam int NUM_CMDS = 40;
	localparam int NUM_TAGS = 1 << `JAC_TAG_W;
	localparam int NN       = `JAC_N * `JAC_N;
	localparam int TIMEOUT  = 2000;

	logic clk        = 1'b0;
	logic rst_n      = 1'b0;
	logic cmd_valid  = 1'b0;
	cmd_t cmd        = '0;
	logic res_credit = 1'b0;
	logic cmd_credit;
	logic res_valid;
	res_t res;

	integer seed      = 6;
	integer hold_seed = 6;

	int  errors;
	int  sent;
	int  results;
	int  cmd_credits;
	int  credit_pulses;
	int  res_valid_cnt;
	int  res_credit_cnt;
	int  owed;
	int  hold_left;
	bit  started;
	bit  timed_out;
	bit  pending [NUM_TAGS];
	op_e exp_op [NUM_TAGS];
	int  exp_c [NUM_TAGS][NN];

	jacobian_top jacobian_top_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.cmd_valid  (cmd_valid),
		.cmd        (cmd),
		.cmd_credit (cmd_credit),
		.res_valid  (res_valid),
		.res        (res),
		.res_credit (res_credit)
	);

	always #20 clk = ~clk;

	// Builds command n, stores its reference result and drives it for one cycle.
	task automatic send_cmd(input int n);
		logic signed [`JAC_DATA_W-1:0] ea;
		logic signed [`JAC_DATA_W-1:0] eb;
		logic [`JAC_TAG_W-1:0]         tag;
		op_e                           op;
		int                            a [NN];
		int                            b [NN];
		int                            sum;
		tag     = n[`JAC_TAG_W-1:0];
		op      = (n % 2 == 0) ? OP_MAT : OP_ARRAY;
		cmd.tag = tag;
		cmd.op  = op;
		for (int k = 0; k < NN; k++) begin
			ea       = $random(seed);
			eb       = $random(seed);
			cmd.a[k] = ea;
			cmd.b[k] = eb;
			a[k]     = ea;
			b[k]     = eb;
		end
		// Element i,j of the product or of the element-wise product.
		for (int i = 0; i < `JAC_N; i++) begin
			for (int j = 0; j < `JAC_N; j++) begin
				sum = 0;
				if (op == OP_MAT) begin
					for (int kk = 0; kk < `JAC_N; kk++)
						sum += a[i*`JAC_N + kk] * b[kk*`JAC_N + j];
				end else begin
					sum = a[i*`JAC_N + j] * b[i*`JAC_N + j];
				end
				exp_c[tag][i*`JAC_N + j] = sum;
			end
		end
		exp_op[tag]  = op;
		pending[tag] = 1'b1;
		cmd_valid    = 1'b1;
		cmd_credits--;
		started = 1'b1;
		sent++;
		@(posedge clk);
		#1;
		cmd_valid = 1'b0;
	endtask

	// Waits for a command credit and for the tag to be free again.
	task automatic wait_for_slot(input int tag);
		int cycles;
		cycles = 0;
		while ((cmd_credits == 0 || pending[tag]) && cycles < TIMEOUT) begin
			@(posedge clk);
			#1;
			cycles++;
		end
		if (cmd_credits == 0 || pending[tag]) begin
			errors++;
			timed_out = 1'b1;
			$display("Timeout at %0t: no command credit or tag %0d still in flight", $time, tag);
		end
	endtask

	task automatic wait_for_drain();
		int cycles;
		cycles = 0;
		while (results < sent && cycles < TIMEOUT) begin
			@(posedge clk);
			#1;
			cycles++;
		end
		if (results < sent) begin
			errors++;
			timed_out = 1'b1;
			$display("Timeout at %0t: only %0d of %0d results came back", $time, results, sent);
		end
	endtask

	task automatic check_result();
		int got;
		assert (pending[res.tag]) else begin
			errors++;
			$display("Result with tag %0d at %0t was not issued or came back twice",
				res.tag, $time);
		end
		if (pending[res.tag]) begin
			assert (res.op == exp_op[res.tag]) else begin
				errors++;
				$display("mismatch at %0t: res.op expected %0d got %0d",
					$time, exp_op[res.tag], res.op);
			end
			for (int k = 0; k < NN; k++) begin
				got = res.c[k];
				assert (got == exp_c[res.tag][k]) else begin
					errors++;
					$display("mismatch at %0t: res.c[%0d] expected %0d got %0d",
						$time, k, exp_c[res.tag][k], got);
				end
			end
			pending[res.tag] = 1'b0;
			results++;
		end
	endtask

	// Outputs are sampled mid-cycle.
	always @(negedge clk) begin
		if (!started) begin
			assert (!cmd_credit && !res_valid) else begin
				errors++;
				$display("cmd_credit or res_valid active at %0t before any command", $time);
			end
		end
		if (rst_n) begin
			if (cmd_credit) begin
				credit_pulses++;
				cmd_credits++;
			end
			if (res_valid) begin
				res_valid_cnt++;
				owed++;
				check_result();
			end
			assert (res_valid_cnt <= `JAC_RES_CREDITS + res_credit_cnt) else begin
				errors++;
				$display("res_valid raised without a result credit at %0t", $time);
			end
			if (res_credit)
				res_credit_cnt++;
		end
	end

	// Downstream returns credits, with random stretches of holding them back.
	always @(posedge clk) begin
		#1;
		res_credit = 1'b0;
		if (rst_n) begin
			if (hold_left > 0) begin
				hold_left--;
			end else if (($random(hold_seed) & 7) == 0) begin
				hold_left = 6 + ($random(hold_seed) & 15);
			end else if (owed > 0) begin
				res_credit = 1'b1;
				owed--;
			end
		end
	end

	initial begin
		cmd_credits = `JAC_CMD_DEPTH;
		repeat (16) @(posedge clk);
		#1;
		rst_n = 1'b1;
		// Idle window after reset.
		repeat (6) @(posedge clk);
		#1;
		for (int n = 0; n < NUM_CMDS && !timed_out; n++) begin
			wait_for_slot(n % NUM_TAGS);
			if (!timed_out) begin
				send_cmd(n);
				repeat ($random(seed) & 1) begin
					@(posedge clk);
					#1;
				end
			end
		end
		if (!timed_out)
			wait_for_drain();
		repeat (4) @(posedge clk);
		assert (credit_pulses == sent) else begin
			errors++;
			$display("mismatch at %0t: cmd_credit pulses expected %0d got %0d",
				$time, sent, credit_pulses);
		end
		for (int t = 0; t < NUM_TAGS; t++) begin
			assert (!pending[t]) else begin
				errors++;
				$display("Tag %0d was issued but never returned", t);
			end
		end
		$display("Errors: %0d, commands sent: %0d, results checked: %0d",
			errors, sent, results);
		if (errors == 0 && !timed_out)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

// ==== sim.f ====
+incdir+hdl
hdl/jacobian_pkg.sv
hdl/jacobian_seq.sv
hdl/mat_mult.sv
hdl/array_mult.sv
hdl/result_arbiter.sv
hdl/jacobian_top.sv
testbench/jacobian_tb.sv

// ==== Makefile ====
SRCS = $(filter-out +%,$(shell cat sim.f)) hdl/jacobian_consts.svh

.PHONY: all run clean

all: run

obj_dir/Vjacobian_tb: sim.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f sim.f \
		--top-module jacobian_tb -o Vjacobian_tb

run: obj_dir/Vjacobian_tb
	obj_dir/Vjacobian_tb > sim.log 2>&1; cat sim.log
	@if grep -q "Regression failed" sim.log; then exit 1; fi
	@grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log
